/* filelist.f */
riscv_pkg.sv
riscv_if.sv
riscv_iq.sv
riscv_rf.sv
riscv_ex.sv
riscv_core.sv
tb_clk_gen.sv
tb_riscv_core.sv

/* run.sh */
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_riscv_core -f filelist.f -o sim_riscv_core \
  || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_riscv_core)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

/* tb_riscv_core.sv */
/*
  Testbench for the RV32I core
  Serves the four-phase instruction bus from a program table, checks
  every retirement against hand-computed results and holds a debug
  stall partway through the program
*/

`default_nettype none

module tb_riscv_core
  import riscv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          XLEN         = XLEN_DEFAULT;
  localparam logic [31:0] PC_INIT      = PC_INIT_DEFAULT;
  localparam int          IQ_DEPTH     = IQ_DEPTH_DEFAULT;
  localparam int unsigned RAND_SEED    = 32'h38becf75;
  localparam logic [31:0] NOP_INSN     = 32'h0000_0013;   // ADDI x0,x0,0
  localparam int          STALL_ROW    = 12;              // Stall once this row retired
  localparam int          STALL_CYCLES = 20;
  localparam int          RESET_LIMIT  = 20;
  localparam int          RETIRE_LIMIT = 200;
  localparam int          IDLE_LIMIT   = 100;
  localparam int          ACK_LIMIT    = 10;

  logic            clk;
  logic            reset;
  logic            imem_req;
  logic [XLEN-1:0] imem_adr;
  logic            imem_ack;
  logic [ILEN-1:0] imem_insn;
  logic            dbg_stall;
  logic            wb_valid;
  logic [XLEN-1:0] wb_pc;
  rsd_t            wb_dst;
  logic            wb_we;
  logic [XLEN-1:0] wb_r;

  // Program table and expected retirements
  logic [31:0] tbl_insn [$];
  rsd_t        tbl_rd   [$];
  logic        tbl_we   [$];
  logic [31:0] tbl_r    [$];

  // Observed retirements in order
  logic [31:0] rt_pc  [$];
  rsd_t        rt_dst [$];
  logic        rt_we  [$];
  logic [31:0] rt_r   [$];

  int   retire_cnt = 0;
  int   fetch_done = 0;    // Words taken by the core
  int   val_errs   = 0;
  int   other_errs = 0;
  logic abort      = 1'b0;

  tb_clk_gen #(
    .PERIOD       ( 40 ),
    .RESET_CYCLES ( 4  ) )
  u_clk_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset ) );

  riscv_core #(
    .XLEN     ( XLEN     ),
    .PC_INIT  ( PC_INIT  ),
    .IQ_DEPTH ( IQ_DEPTH ) )
  u_dut (
    .clk_i       ( clk       ),
    .reset_i     ( reset     ),
    .imem_req_o  ( imem_req  ),
    .imem_adr_o  ( imem_adr  ),
    .imem_ack_i  ( imem_ack  ),
    .imem_insn_i ( imem_insn ),
    .dbg_stall_i ( dbg_stall ),
    .wb_valid_o  ( wb_valid  ),
    .wb_pc_o     ( wb_pc     ),
    .wb_dst_o    ( wb_dst    ),
    .wb_we_o     ( wb_we     ),
    .wb_r_o      ( wb_r      ) );

  //////////////////////////////////////////////////////////////////////
  // Instruction encoders and program
  //////////////////////////////////////////////////////////////////////

  function automatic logic [2:0] funct3_of(input alu_op_t op);
    case (op)
      ALU_SLL:          return 3'b001;
      ALU_SLT:          return 3'b010;
      ALU_SLTU:         return 3'b011;
      ALU_XOR:          return 3'b100;
      ALU_SRL, ALU_SRA: return 3'b101;
      ALU_OR:           return 3'b110;
      ALU_AND:          return 3'b111;
      default:          return 3'b000;    // ADD and SUB
    endcase
  endfunction

  function automatic logic [31:0] enc_rr(input alu_op_t op, input rsd_t rd,
                                        input rsd_t rs1, input rsd_t rs2);
    logic [6:0] funct7;
    funct7 = (op == ALU_SUB || op == ALU_SRA) ? 7'b0100000 : 7'b0000000;
    return {funct7, rs2, rs1, funct3_of(op), rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_ri(input alu_op_t op, input rsd_t rd,
                                        input rsd_t rs1, input logic [11:0] imm);
    logic [11:0] field;
    field = (op == ALU_SRA) ? {7'b0100000, imm[4:0]} : imm;   // SRAI marker
    return {field, rs1, funct3_of(op), rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input rsd_t rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  task automatic add_row(input logic [31:0] insn, input rsd_t rd, input logic we,
                         input logic [31:0] r);
    tbl_insn.push_back(insn);
    tbl_rd.push_back(rd);
    tbl_we.push_back(we);
    tbl_r.push_back(r);
  endtask

  task automatic build_program();
    add_row(enc_ri(ALU_ADD, 5'd1, 5'd0, 12'd5), 5'd1, 1'b1, 32'h0000_0005);
    add_row(enc_ri(ALU_ADD, 5'd2, 5'd0, 12'hffd), 5'd2, 1'b1, 32'hffff_fffd);  // -3
    add_row(enc_rr(ALU_ADD, 5'd3, 5'd1, 5'd2), 5'd3, 1'b1, 32'h0000_0002);
    add_row(enc_rr(ALU_SUB, 5'd4, 5'd1, 5'd2), 5'd4, 1'b1, 32'h0000_0008);
    add_row(enc_rr(ALU_AND, 5'd5, 5'd1, 5'd2), 5'd5, 1'b1, 32'h0000_0005);
    add_row(enc_rr(ALU_OR, 5'd6, 5'd1, 5'd2), 5'd6, 1'b1, 32'hffff_fffd);
    add_row(enc_rr(ALU_XOR, 5'd7, 5'd1, 5'd2), 5'd7, 1'b1, 32'hffff_fff8);
    add_row(enc_rr(ALU_SLT, 5'd8, 5'd2, 5'd1), 5'd8, 1'b1, 32'h0000_0001);
    add_row(enc_rr(ALU_SLTU, 5'd9, 5'd2, 5'd1), 5'd9, 1'b1, 32'h0000_0000);
    add_row(enc_rr(ALU_SLL, 5'd10, 5'd1, 5'd3), 5'd10, 1'b1, 32'h0000_0014);
    add_row(enc_rr(ALU_SRL, 5'd11, 5'd2, 5'd3), 5'd11, 1'b1, 32'h3fff_ffff);
    add_row(enc_rr(ALU_SRA, 5'd12, 5'd2, 5'd3), 5'd12, 1'b1, 32'hffff_ffff);
    add_row(enc_lui(5'd13, 20'h12345), 5'd13, 1'b1, 32'h1234_5000);
    add_row(enc_ri(ALU_XOR, 5'd14, 5'd13, 12'hfff), 5'd14, 1'b1, 32'hedcb_afff);
    add_row(enc_ri(ALU_OR, 5'd15, 5'd1, 12'h0f0), 5'd15, 1'b1, 32'h0000_00f5);
    add_row(enc_ri(ALU_AND, 5'd16, 5'd14, 12'h7ff), 5'd16, 1'b1, 32'h0000_07ff);
    add_row(enc_ri(ALU_SLT, 5'd17, 5'd2, 12'hffe), 5'd17, 1'b1, 32'h0000_0001);
    add_row(enc_ri(ALU_SLTU, 5'd18, 5'd1, 12'hfff), 5'd18, 1'b1, 32'h0000_0001);
    add_row(enc_ri(ALU_SLL, 5'd19, 5'd1, 12'd4), 5'd19, 1'b1, 32'h0000_0050);
    add_row(enc_ri(ALU_SRL, 5'd20, 5'd14, 12'd8), 5'd20, 1'b1, 32'h00ed_cbaf);
    add_row(enc_ri(ALU_SRA, 5'd21, 5'd14, 12'd8), 5'd21, 1'b1, 32'hffed_cbaf);
    add_row(enc_ri(ALU_ADD, 5'd0, 5'd1, 12'd7), 5'd0, 1'b0, 32'h0);    // Write to x0
    add_row(enc_rr(ALU_ADD, 5'd22, 5'd0, 5'd1), 5'd22, 1'b1, 32'h0000_0005);
    add_row(32'h0000_02ef, 5'd5, 1'b0, 32'h0);                         // JAL x5 as no-op
    add_row(enc_ri(ALU_ADD, 5'd23, 5'd22, 12'd1), 5'd23, 1'b1, 32'h0000_0006);
    add_row(enc_lui(5'd24, 20'hfffff), 5'd24, 1'b1, 32'hffff_f000);
    add_row(enc_rr(ALU_SUB, 5'd25, 5'd24, 5'd1), 5'd25, 1'b1, 32'hffff_effb);
    add_row(enc_ri(ALU_SRA, 5'd26, 5'd24, 12'd12), 5'd26, 1'b1, 32'hffff_ffff);
    add_row(enc_rr(ALU_SLTU, 5'd27, 5'd0, 5'd24), 5'd27, 1'b1, 32'h0000_0001);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      val_errs++;
      $display("ERR %s: got %08h, expected %08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errs++;
    abort = 1'b1;
    $display("%s at %0t", msg, $time);
  endtask

  task automatic step_edge();
    @(posedge clk);
    #2;
  endtask

  // Beyond the table the memory holds NOPs
  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    int idx;
    idx = int'((adr - PC_INIT) >> 2);
    if (adr >= PC_INIT && idx < tbl_insn.size())
      return tbl_insn[idx];
    return NOP_INSN;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Instruction memory responder
  //////////////////////////////////////////////////////////////////////

  initial
  begin : mem_responder
    int          n;
    int unsigned dly;
    imem_ack  = 1'b0;
    imem_insn = '0;
    void'($urandom(RAND_SEED));
    while (!abort)
    begin
      n = 0;
      step_edge();
      while (!imem_req && n < IDLE_LIMIT)
      begin
        step_edge();
        n++;
      end
      if (!imem_req)
      begin
        note_failure("Core issued no fetch request");
        break;
      end
      check_value("imem_adr_o", imem_adr, PC_INIT + 32'(4 * fetch_done));
      dly = $urandom_range(3, 0);
      repeat (dly) step_edge();
      imem_insn = fetch_word(imem_adr);
      imem_ack  = 1'b1;
      n = 0;
      step_edge();
      while (imem_req && n < ACK_LIMIT)        // req must drop after capture
      begin
        step_edge();
        n++;
      end
      if (imem_req)
      begin
        note_failure("Core kept req high after ack");
        break;
      end
      fetch_done++;
      dly = $urandom_range(3, 0);
      repeat (dly) step_edge();
      imem_ack = 1'b0;
    end
  end

  // Mid-cycle capture of every retirement
  initial
  begin : retire_monitor
    forever
    begin
      @(negedge clk);
      if (wb_valid === 1'b1)
      begin
        rt_pc.push_back(wb_pc);
        rt_dst.push_back(wb_dst);
        rt_we.push_back(wb_we);
        rt_r.push_back(wb_r);
        retire_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checking sequence
  //////////////////////////////////////////////////////////////////////

  task automatic check_retire(input int row);
    int n;
    n = 0;
    while (retire_cnt <= row && n < RETIRE_LIMIT && !abort)
    begin
      @(posedge clk);
      n++;
    end
    if (retire_cnt <= row)
    begin
      if (!abort)
        note_failure($sformatf("Timeout waiting for row %0d to retire", row));
    end
    else
    begin
      check_value("wb_pc_o", rt_pc[row], PC_INIT + 32'(4 * row));
      check_value("wb_dst_o", 32'(rt_dst[row]), 32'(tbl_rd[row]));
      check_value("wb_we_o", 32'(rt_we[row]), 32'(tbl_we[row]));
      if (tbl_we[row])
        check_value("wb_r_o", rt_r[row], tbl_r[row]);   // Result matters only for writes
    end
  endtask

  task automatic hold_stall();
    int c;
    int occ;
    int full_cycles;
    full_cycles = 0;
    @(posedge clk);
    #2;
    dbg_stall = 1'b1;
    @(posedge clk);                  // First edge that sees the stall
    for (c = 0; c < STALL_CYCLES - 1; c++)
    begin
      #10;
      check_value("wb_valid_o", 32'(wb_valid), 32'h0);
      occ = fetch_done - retire_cnt;   // Words held in the queue
      if (occ > IQ_DEPTH)
        note_failure("More words fetched than the queue can hold");
      else if (occ == IQ_DEPTH)
      begin
        full_cycles++;
        check_value("imem_req_o", 32'(imem_req), 32'h0);
      end
      @(posedge clk);
    end
    #2;
    dbg_stall = 1'b0;
    $display("Stall released, queue full in %0d of %0d cycles", full_cycles,
             STALL_CYCLES - 1);
  endtask

  initial
  begin : main_seq
    int n;
    int i;
    dbg_stall = 1'b0;
    build_program();

    // Outputs quiet through reset
    n = 0;
    while (n < RESET_LIMIT)
    begin
      @(negedge clk);
      check_value("imem_req_o", 32'(imem_req), 32'h0);
      check_value("wb_valid_o", 32'(wb_valid), 32'h0);
      n++;
      if (!reset)
        break;
    end
    if (reset)
      note_failure("Reset was never released");
    else
      check_value("imem_adr_o", imem_adr, PC_INIT);

    for (i = 0; i < tbl_insn.size() && !abort; i++)
    begin
      check_retire(i);
      if (i == STALL_ROW)
        hold_stall();
    end

    $display("Checks done: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
  Testbench clock and reset generator
  Free-running clock, reset held high for the first few rising edges
*/

`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 4
)
(
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Released just after an edge, like every other input
  initial
  begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* riscv_core.sv */
/*
  RV32I integer core, top level
  Fetch feeds the instruction queue, which feeds the combined
  decode/execute/write-back stage and the integer register file.
*/

`default_nettype none

module riscv_core
  import riscv_pkg::*;
#(
  parameter int              XLEN     = XLEN_DEFAULT,
  parameter logic [XLEN-1:0] PC_INIT  = PC_INIT_DEFAULT,
  parameter int              IQ_DEPTH = IQ_DEPTH_DEFAULT
)
(
  input  logic            clk_i,
  input  logic            reset_i,

  // Instruction memory bus
  output logic            imem_req_o,
  output logic [XLEN-1:0] imem_adr_o,
  input  logic            imem_ack_i,
  input  logic [ILEN-1:0] imem_insn_i,

  input  logic            dbg_stall_i,

  // Retire port
  output logic            wb_valid_o,
  output logic [XLEN-1:0] wb_pc_o,
  output rsd_t            wb_dst_o,
  output logic            wb_we_o,
  output logic [XLEN-1:0] wb_r_o
);

  // Fetch to queue
  logic            iq_push;
  logic [XLEN-1:0] iq_push_pc;
  logic [ILEN-1:0] iq_push_insn;
  logic            iq_full;

  // Queue to execute
  logic            iq_empty;
  logic            iq_pop;
  logic [XLEN-1:0] iq_pc;
  logic [ILEN-1:0] iq_insn;

  // Register file access
  rsd_t            rf_src1;
  rsd_t            rf_src2;
  logic [XLEN-1:0] rf_srcv1;
  logic [XLEN-1:0] rf_srcv2;
  rsd_t            rf_dst;
  logic            rf_we;
  logic [XLEN-1:0] rf_dst_d;

  //////////////////////////////////////////////////////////////////////
  // Instruction fetch
  //////////////////////////////////////////////////////////////////////

  riscv_if #(
    .XLEN        ( XLEN         ),
    .PC_INIT     ( PC_INIT      ) )
  if_unit (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .imem_req_o  ( imem_req_o   ),
    .imem_adr_o  ( imem_adr_o   ),
    .imem_ack_i  ( imem_ack_i   ),
    .imem_insn_i ( imem_insn_i  ),
    .iq_push_o   ( iq_push      ),
    .iq_pc_o     ( iq_push_pc   ),
    .iq_insn_o   ( iq_push_insn ),
    .iq_full_i   ( iq_full      ) );

  // Decouples fetch from execute stalls
  riscv_iq #(
    .XLEN        ( XLEN         ),
    .IQ_DEPTH    ( IQ_DEPTH     ) )
  iq_unit (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .push_i      ( iq_push      ),
    .push_pc_i   ( iq_push_pc   ),
    .push_insn_i ( iq_push_insn ),
    .full_o      ( iq_full      ),
    .pop_i       ( iq_pop       ),
    .empty_o     ( iq_empty     ),
    .pc_o        ( iq_pc        ),
    .insn_o      ( iq_insn      ) );

  //////////////////////////////////////////////////////////////////////
  // Execute and register file
  //////////////////////////////////////////////////////////////////////

  riscv_ex #(
    .XLEN        ( XLEN         ) )
  ex_unit (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .iq_empty_i  ( iq_empty     ),
    .iq_pc_i     ( iq_pc        ),
    .iq_insn_i   ( iq_insn      ),
    .iq_pop_o    ( iq_pop       ),
    .dbg_stall_i ( dbg_stall_i  ),
    .rf_src1_o   ( rf_src1      ),
    .rf_src2_o   ( rf_src2      ),
    .rf_src1_q_i ( rf_srcv1     ),
    .rf_src2_q_i ( rf_srcv2     ),
    .rf_dst_o    ( rf_dst       ),
    .rf_we_o     ( rf_we        ),
    .rf_dst_d_o  ( rf_dst_d     ),
    .wb_valid_o  ( wb_valid_o   ),
    .wb_pc_o     ( wb_pc_o      ),
    .wb_dst_o    ( wb_dst_o     ),
    .wb_we_o     ( wb_we_o      ),
    .wb_r_o      ( wb_r_o       ) );

  riscv_rf #(
    .XLEN        ( XLEN         ) )
  int_rf (
    .clk_i       ( clk_i        ),
    .rf_src1_i   ( rf_src1      ),
    .rf_src2_i   ( rf_src2      ),
    .rf_src1_q_o ( rf_srcv1     ),
    .rf_src2_q_o ( rf_srcv2     ),
    .rf_dst_i    ( rf_dst       ),
    .rf_we_i     ( rf_we        ),
    .rf_dst_d_i  ( rf_dst_d     ) );

endmodule

`default_nettype wire

/* riscv_ex.sv */
/*
  Decode, execute and write-back stage
  Decodes the queue head, reads operands, computes the ALU result and
  writes the register file on the pop edge. Retire information is
  registered and valid for one cycle after the pop.
*/

`default_nettype none

module riscv_ex
  import riscv_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
)
(
  input  logic            clk_i,
  input  logic            reset_i,

  // Instruction queue head
  input  logic            iq_empty_i,
  input  logic [XLEN-1:0] iq_pc_i,
  input  logic [ILEN-1:0] iq_insn_i,
  output logic            iq_pop_o,

  input  logic            dbg_stall_i,     // Hold execution

  // Register file
  output rsd_t            rf_src1_o,
  output rsd_t            rf_src2_o,
  input  logic [XLEN-1:0] rf_src1_q_i,
  input  logic [XLEN-1:0] rf_src2_q_i,
  output rsd_t            rf_dst_o,
  output logic            rf_we_o,
  output logic [XLEN-1:0] rf_dst_d_o,

  // Retire port
  output logic            wb_valid_o,
  output logic [XLEN-1:0] wb_pc_o,
  output rsd_t            wb_dst_o,
  output logic            wb_we_o,
  output logic [XLEN-1:0] wb_r_o
);

  localparam int SHW = $clog2(XLEN);   // Shift amount width

  opcode_t         opcode;
  alu_op_t         alu_op;
  logic [2:0]      funct3;
  logic            funct7_b5;
  rsd_t            rd;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] alu_r;
  logic            supported;
  logic            writes_rd;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign opcode    = opcode_t'(iq_insn_i[6:0]);
  assign rd        = iq_insn_i[11:7];
  assign funct3    = iq_insn_i[14:12];
  assign funct7_b5 = iq_insn_i[30];          // SUB / SRA select
  assign rf_src1_o = iq_insn_i[19:15];
  assign rf_src2_o = iq_insn_i[24:20];

  // Sign-extended immediates
  assign imm_i = XLEN'($signed(iq_insn_i[31:20]));
  assign imm_u = XLEN'($signed({iq_insn_i[31:12], 12'h000}));

  always_comb
  begin
    supported = 1'b1;
    alu_op    = ALU_ADD;
    case (opcode)
      OPC_OP, OPC_OP_IMM:
      begin
        case (funct3)
          3'b000:  alu_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b101:  alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_LUI: alu_op    = ALU_PASSB;
      default: supported = 1'b0;          // Retires as a no-op
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  assign opa   = rf_src1_q_i;
  assign opb   = (opcode == OPC_OP)  ? rf_src2_q_i :
                 (opcode == OPC_LUI) ? imm_u       : imm_i;
  assign shamt = opb[SHW-1:0];

  always_comb
  begin
    case (alu_op)
      ALU_ADD:   alu_r = opa + opb;
      ALU_SUB:   alu_r = opa - opb;
      ALU_AND:   alu_r = opa & opb;
      ALU_OR:    alu_r = opa | opb;
      ALU_XOR:   alu_r = opa ^ opb;
      ALU_SLT:   alu_r = XLEN'($signed(opa) < $signed(opb));
      ALU_SLTU:  alu_r = XLEN'(opa < opb);
      ALU_SLL:   alu_r = opa << shamt;
      ALU_SRL:   alu_r = opa >> shamt;
      ALU_SRA:   alu_r = $signed(opa) >>> shamt;    // Keeps the sign
      ALU_PASSB: alu_r = opb;
      default:   alu_r = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Write-back and retire
  //////////////////////////////////////////////////////////////////////

  // Only supported opcodes with a non-zero rd write
  assign writes_rd = supported & (rd != '0);

  assign iq_pop_o   = ~iq_empty_i & ~dbg_stall_i;
  assign rf_we_o    = iq_pop_o & writes_rd;
  assign rf_dst_o   = rd;
  assign rf_dst_d_o = alu_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      wb_valid_o <= 1'b0;
    else
      wb_valid_o <= iq_pop_o;
  end

  always_ff @(posedge clk_i)
  begin
    if (iq_pop_o)
    begin
      wb_pc_o  <= iq_pc_i;
      wb_dst_o <= rd;
      wb_we_o  <= writes_rd;
      wb_r_o   <= alu_r;
    end
  end

endmodule

`default_nettype wire

/* riscv_rf.sv */
/*
  Integer register file
  Two combinational read ports and one write port.
  x0 has no storage and always reads zero.
*/

`default_nettype none

module riscv_rf
  import riscv_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
)
(
  input  logic            clk_i,

  input  rsd_t            rf_src1_i,
  input  rsd_t            rf_src2_i,
  output logic [XLEN-1:0] rf_src1_q_o,
  output logic [XLEN-1:0] rf_src2_q_o,

  input  rsd_t            rf_dst_i,
  input  logic            rf_we_i,
  input  logic [XLEN-1:0] rf_dst_d_i
);

  logic [XLEN-1:0] regs    [1:31];   // x1 .. x31
  logic [XLEN-1:0] rd_view [0:31];   // Read view including x0

  assign rd_view[0] = '0;

  // One write decoder per register, x0 has none
  for (genvar i = 1; i < 32; i++)
  begin : g_reg
    always_ff @(posedge clk_i)
    begin
      if (rf_we_i && (rf_dst_i == rsd_t'(i)))
        regs[i] <= rf_dst_d_i;
    end

    assign rd_view[i] = regs[i];
  end

  assign rf_src1_q_o = rd_view[rf_src1_i];
  assign rf_src2_q_o = rd_view[rf_src2_i];

endmodule

`default_nettype wire

/* riscv_iq.sv */
/*
  Instruction queue
  Circular FIFO of PC/instruction pairs between fetch and execute.
  The head entry is presented combinationally.
*/

`default_nettype none

module riscv_iq
  import riscv_pkg::*;
#(
  parameter int XLEN     = XLEN_DEFAULT,
  parameter int IQ_DEPTH = IQ_DEPTH_DEFAULT
)
(
  input  logic            clk_i,
  input  logic            reset_i,

  input  logic            push_i,
  input  logic [XLEN-1:0] push_pc_i,
  input  logic [ILEN-1:0] push_insn_i,
  output logic            full_o,

  input  logic            pop_i,
  output logic            empty_o,
  output logic [XLEN-1:0] pc_o,
  output logic [ILEN-1:0] insn_o
);

  localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  logic [XLEN-1:0]  pc_mem   [IQ_DEPTH];
  logic [ILEN-1:0]  insn_mem [IQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;       // Occupancy
  logic             do_push;
  logic             do_pop;

  // Wrap at IQ_DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(IQ_DEPTH - 1)) ? '0 : p + PTR_W'(1);
  endfunction

  assign full_o  = (count == CNT_W'(IQ_DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      pc_mem[wr_ptr]   <= push_pc_i;
      insn_mem[wr_ptr] <= push_insn_i;
    end
  end

  // Pointers and count
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);

      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;         // Both or neither
      endcase
    end
  end

  assign pc_o   = pc_mem[rd_ptr];
  assign insn_o = insn_mem[rd_ptr];

endmodule

`default_nettype wire

/* riscv_if.sv */
/*
  Instruction fetch unit
  Holds the PC and runs the four-phase req/ack handshake on the
  instruction memory bus. Each captured word is pushed into the
  instruction queue together with its PC.
*/

`default_nettype none

module riscv_if
  import riscv_pkg::*;
#(
  parameter int              XLEN    = XLEN_DEFAULT,
  parameter logic [XLEN-1:0] PC_INIT = PC_INIT_DEFAULT
)
(
  input  logic            clk_i,
  input  logic            reset_i,

  // Instruction memory bus
  output logic            imem_req_o,
  output logic [XLEN-1:0] imem_adr_o,
  input  logic            imem_ack_i,
  input  logic [ILEN-1:0] imem_insn_i,

  // Instruction queue write side
  output logic            iq_push_o,
  output logic [XLEN-1:0] iq_pc_o,
  output logic [ILEN-1:0] iq_insn_o,
  input  logic            iq_full_i
);

  typedef enum logic [1:0] {
    IF_IDLE,           // Waiting for room in the queue
    IF_REQ,            // req high, waiting for ack
    IF_WAIT_ACK_LOW    // Word taken, waiting for ack to drop
  } if_state_t;

  if_state_t       state;
  logic [XLEN-1:0] pc;
  logic            capture;

  // First cycle with ack seen while requesting
  assign capture = (state == IF_REQ) & imem_ack_i;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM and PC
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state <= IF_IDLE;
      pc    <= PC_INIT;
    end
    else
    begin
      case (state)
        IF_IDLE:
        begin
          if (!iq_full_i)
            state <= IF_REQ;
        end
        IF_REQ:
        begin
          if (imem_ack_i)
          begin
            state <= IF_WAIT_ACK_LOW;
            pc    <= pc + XLEN'(4);   // Sequential only
          end
        end
        IF_WAIT_ACK_LOW:
        begin
          // Next request straight away if the queue has room
          if (!imem_ack_i)
            state <= iq_full_i ? IF_IDLE : IF_REQ;
        end
        default: state <= IF_IDLE;
      endcase
    end
  end

  assign imem_req_o = (state == IF_REQ);
  assign imem_adr_o = pc;               // Stable while req is high

  // Push in the capture cycle
  assign iq_push_o = capture;
  assign iq_pc_o   = pc;
  assign iq_insn_o = imem_insn_i;

endmodule

`default_nettype wire

/* riscv_pkg.sv */
/*
  RV32I core shared definitions
  Widths and reset defaults, major opcode encodings, ALU operations
  and the register index type
*/

`default_nettype none

package riscv_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes and defaults
  //////////////////////////////////////////////////////////////////////

  localparam int          XLEN_DEFAULT     = 32;
  localparam int          ILEN             = 32;        // Instruction word
  localparam int          IQ_DEPTH_DEFAULT = 4;
  localparam logic [31:0] PC_INIT_DEFAULT  = 32'h200;   // Reset vector

  // Integer register index
  typedef logic [4:0] rsd_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcode, insn[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,   // Register-register
    OPC_OP_IMM = 7'b0010011,   // Register-immediate
    OPC_LUI    = 7'b0110111
  } opcode_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASSB    // Operand B straight through, used by LUI
  } alu_op_t;

endpackage

`default_nettype wire
